/* source/cw_route_pkg.sv */
package cw_route_pkg;

	localparam int APB_ADDR_W    = 8;  // byte address
	localparam int APB_DATA_W    = 32;
	localparam int N_TARGET_PINS = 4;  // index 0 is target io pin 1

	// register map, word aligned byte addresses
	localparam logic [APB_ADDR_W-1:0] ADDR_TRIGSRC    = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_TRIGMOD    = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_PIN_ROUTE0 = 8'h08;
	localparam logic [APB_ADDR_W-1:0] ADDR_PIN_ROUTE1 = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] ADDR_PIN_ROUTE2 = 8'h10;
	localparam logic [APB_ADDR_W-1:0] ADDR_PIN_ROUTE3 = 8'h14;
	localparam logic [APB_ADDR_W-1:0] ADDR_POWER      = 8'h18;

	typedef enum logic [1:0] {COMBINE_OR = 2'd0, COMBINE_AND = 2'd1} trig_combine_e; // 2, 3 unused
	typedef enum logic [2:0] {TRIG_EDGE = 3'd0, TRIG_ADVIO = 3'd1, TRIG_ANAPATTERN = 3'd2} trig_module_e;
	typedef enum logic [1:0] {PWR_STEADY = 2'd0, PWR_RAMP = 2'd1} pwr_state_e;

	typedef struct packed {
		logic io4; logic io3; logic io2; logic io1; logic fpb; logic fpa; // fpa in bit 0
	} trig_lines_t;

	typedef struct packed {
		trig_module_e  module_sel; // from TRIGMOD[2:0]
		trig_combine_e combine;    // TRIGSRC[7:6]
		trig_lines_t   src_mask;   // TRIGSRC[5:0]
	} trig_cfg_t;

	typedef struct packed {
		logic drive; logic level; logic tx_oc; logic usi_oc; // upper nibble
		logic usi_in; logic usi_out; logic uart_rx; logic uart_tx; // uart_tx in bit 0
	} pin_route_t;

	typedef struct packed {logic fast_start; logic off;} power_cfg_t; // off in bit 0
	typedef struct packed {logic oe; logic value;} pin_drive_t;

	typedef struct packed {
		logic psel; logic penable; logic pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {logic [APB_DATA_W-1:0] prdata; logic pready; logic pslverr;} apb_rsp_t;

	localparam logic [7:0] RST_TRIGSRC = 8'h01; // fpa only, OR combine
	localparam logic [7:0] RST_TRIGMOD = 8'h00; // edge mode
	localparam pin_route_t [N_TARGET_PINS-1:0] RST_PIN_ROUTE = {8'h00, 8'h00, 8'h02, 8'h01};
	localparam logic [7:0] RST_POWER   = 8'h00; // power on, slow start

endpackage

/* source/cw_apb_regs.sv */
`timescale 1ns/1ps

module cw_apb_regs (
	input  logic                                                    clk,
	input  logic                                                    reset,
	input  cw_route_pkg::apb_req_t                                  apb_i,
	output cw_route_pkg::apb_rsp_t                                  apb_o,
	output cw_route_pkg::trig_cfg_t                                 trig_cfg_o,
	output cw_route_pkg::pin_route_t [cw_route_pkg::N_TARGET_PINS-1:0] pin_route_o,
	output cw_route_pkg::power_cfg_t                                power_cfg_o
);
	import cw_route_pkg::*;

	logic [7:0] trigsrc_q; // [7:6] combine, [5:0] source mask
	logic [7:0] trigmod_q; // [2:0] module select, rest kept as written
	pin_route_t [N_TARGET_PINS-1:0] pin_route_q;
	logic [7:0] power_q;   // [0] off, [1] fast start

	logic       access;    // apb access phase
	logic       wr_en;
	logic       addr_hit;
	logic [7:0] rd_byte;

	assign access = apb_i.psel & apb_i.penable;
	assign wr_en  = access & apb_i.pwrite & addr_hit;

	// address decode and read mux
	always_comb begin
		rd_byte  = 8'h00;
		addr_hit = 1'b1;
		case (apb_i.paddr)
			ADDR_TRIGSRC:    rd_byte = trigsrc_q;
			ADDR_TRIGMOD:    rd_byte = trigmod_q;
			ADDR_PIN_ROUTE0: rd_byte = pin_route_q[0];
			ADDR_PIN_ROUTE1: rd_byte = pin_route_q[1];
			ADDR_PIN_ROUTE2: rd_byte = pin_route_q[2];
			ADDR_PIN_ROUTE3: rd_byte = pin_route_q[3];
			ADDR_POWER:      rd_byte = power_q;
			default:         addr_hit = 1'b0; // unmapped, reads zero
		endcase
	end

	// write at the edge closing the access phase
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q   <= RST_TRIGSRC;
			trigmod_q   <= RST_TRIGMOD;
			pin_route_q <= RST_PIN_ROUTE;
			power_q     <= RST_POWER;
		end else if (wr_en) begin
			case (apb_i.paddr)
				ADDR_TRIGSRC:    trigsrc_q <= apb_i.pwdata[7:0];
				ADDR_TRIGMOD:    trigmod_q <= apb_i.pwdata[7:0];
				ADDR_PIN_ROUTE0: pin_route_q[0] <= pin_route_t'(apb_i.pwdata[7:0]);
				ADDR_PIN_ROUTE1: pin_route_q[1] <= pin_route_t'(apb_i.pwdata[7:0]);
				ADDR_PIN_ROUTE2: pin_route_q[2] <= pin_route_t'(apb_i.pwdata[7:0]);
				ADDR_PIN_ROUTE3: pin_route_q[3] <= pin_route_t'(apb_i.pwdata[7:0]);
				ADDR_POWER:      power_q <= apb_i.pwdata[7:0];
				default:         ; // never reached, wr_en needs a hit
			endcase
		end
	end

	// zero wait states, every access completes in its access phase
	assign apb_o.pready  = 1'b1;
	assign apb_o.pslverr = access & ~addr_hit;
	assign apb_o.prdata  = access ? {{(APB_DATA_W-8){1'b0}}, rd_byte} : '0; // zero extended

	// unpack register bytes into the datapath configs
	assign trig_cfg_o.src_mask   = trig_lines_t'(trigsrc_q[5:0]);
	assign trig_cfg_o.combine    = trig_combine_e'(trigsrc_q[7:6]);
	assign trig_cfg_o.module_sel = trig_module_e'(trigmod_q[2:0]);
	assign pin_route_o           = pin_route_q;
	assign power_cfg_o           = power_cfg_t'(power_q[1:0]);

endmodule

/* source/trigger_combiner.sv */
`timescale 1ns/1ps

module trigger_combiner (
	input  cw_route_pkg::trig_cfg_t   trig_cfg_i,
	input  cw_route_pkg::trig_lines_t trig_lines_i,
	input  logic                      trigger_advio_i,
	input  logic                      trigger_anapattern_i,
	output logic                      trigger_ext_o,
	output logic                      trigger_o
);
	import cw_route_pkg::*;

	logic [5:0] lines; // raw line values
	logic [5:0] mask;  // 1 = line enabled
	logic       trig_or;
	logic       trig_and;

	assign lines    = trig_lines_i;
	assign mask     = trig_cfg_i.src_mask;
	assign trig_or  = |(lines & mask);  // 0 with empty mask
	assign trig_and = &(lines | ~mask); // disabled lines read as 1, so empty mask gives 1

	always_comb begin
		case (trig_cfg_i.combine)
			COMBINE_OR:  trigger_ext_o = trig_or;
			COMBINE_AND: trigger_ext_o = trig_and;
			default:     trigger_ext_o = 1'b0; // unused combine codes
		endcase
	end

	// trigger module select
	always_comb begin
		case (trig_cfg_i.module_sel)
			TRIG_EDGE:       trigger_o = trigger_ext_o;
			TRIG_ADVIO:      trigger_o = trigger_advio_i;
			TRIG_ANAPATTERN: trigger_o = trigger_anapattern_i;
			default:         trigger_o = 1'b0;
		endcase
	end

endmodule

/* source/target_io_router.sv */
`timescale 1ns/1ps

module target_io_router (
	input  cw_route_pkg::pin_route_t [cw_route_pkg::N_TARGET_PINS-1:0] pin_route_i,
	input  logic [cw_route_pkg::N_TARGET_PINS-1:0]                    targetio_i,
	input  logic                                                      uart_tx_i,
	input  logic                                                      usi_out_i,
	output cw_route_pkg::pin_drive_t [cw_route_pkg::N_TARGET_PINS-1:0] targetio_o,
	output logic                                                      uart_rx_o,
	output logic                                                      usi_in_o
);
	import cw_route_pkg::*;

	// fixed pin capabilities, bit 0 is pin 1
	localparam logic [N_TARGET_PINS-1:0] HAS_USI = 4'b0111; // usi on pins 1 to 3
	localparam logic [N_TARGET_PINS-1:0] HAS_OC  = 4'b0100; // open collector on pin 3 only

	// output side, first true entry wins
	always_comb begin
		for (int p = 0; p < N_TARGET_PINS; p++) begin
			targetio_o[p].value = 1'b0;
			targetio_o[p].oe    = 1'b0; // released unless something drives
			if (pin_route_i[p].uart_tx) begin
				targetio_o[p].value = uart_tx_i;
				targetio_o[p].oe    = 1'b1;
			end else if (HAS_USI[p] && pin_route_i[p].usi_out) begin
				targetio_o[p].value = usi_out_i;
				targetio_o[p].oe    = 1'b1;
			end else if (HAS_OC[p] && pin_route_i[p].usi_oc) begin
				targetio_o[p].oe    = ~usi_out_i; // pull low only
			end else if (HAS_OC[p] && pin_route_i[p].tx_oc) begin
				targetio_o[p].oe    = ~uart_tx_i;
			end else if (pin_route_i[p].drive) begin
				targetio_o[p].value = pin_route_i[p].level; // fixed level
				targetio_o[p].oe    = 1'b1;
			end
		end
	end

	// input side, lowest numbered pin wins
	always_comb begin
		uart_rx_o = 1'b1; // idle high when no pin feeds the receiver
		usi_in_o  = 1'b1;
		for (int p = N_TARGET_PINS - 1; p >= 0; p--) begin
			if (pin_route_i[p].uart_rx) begin
				uart_rx_o = targetio_i[p];
			end
			if (HAS_USI[p] && pin_route_i[p].usi_in) begin
				usi_in_o = targetio_i[p];
			end
		end
	end

endmodule

/* source/target_power_softstart.sv */
`timescale 1ns/1ps

module target_power_softstart #(
	parameter int unsigned PWM_WIDTH        = 11,
	parameter int unsigned PWM_ON_THRESHOLD = 1400,
	parameter int unsigned SOFTSTART_STEPS  = 16384
) (
	input  logic                     clk,
	input  logic                     reset,
	input  cw_route_pkg::power_cfg_t power_cfg_i,
	output logic                     targetpower_off_o
);
	import cw_route_pkg::*;

	localparam int unsigned STEP_W = $clog2(SOFTSTART_STEPS + 1);
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(SOFTSTART_STEPS - 1);
	localparam logic [PWM_WIDTH:0] PWM_ON = (PWM_WIDTH + 1)'(PWM_ON_THRESHOLD);

	pwr_state_e           state_q;
	logic                 off_q;      // registered off bit
	logic                 off_fall;   // off going from 1 to 0
	logic                 pwm_wrap;   // last cycle of a pwm period
	logic                 pwm_on;
	logic [PWM_WIDTH-1:0] pwm_cnt_q;
	logic [STEP_W-1:0]    step_cnt_q; // completed pwm periods

	assign off_fall = off_q & ~power_cfg_i.off;
	assign pwm_wrap = &pwm_cnt_q;
	assign pwm_on   = {1'b0, pwm_cnt_q} < PWM_ON;

	always_ff @(posedge clk) begin
		if (reset) begin
			off_q      <= 1'b0;
			state_q    <= PWR_STEADY;
			pwm_cnt_q  <= '0;
			step_cnt_q <= '0;
		end else begin
			off_q <= power_cfg_i.off;
			case (state_q)
				PWR_STEADY: begin
					if (off_fall && !power_cfg_i.fast_start) begin
						state_q    <= PWR_RAMP; // ramp starts as off_q drops
						pwm_cnt_q  <= '0;
						step_cnt_q <= '0;
					end
				end
				PWR_RAMP: begin
					pwm_cnt_q <= pwm_cnt_q + 1'b1;
					if (pwm_wrap) begin
						step_cnt_q <= step_cnt_q + 1'b1;
					end
					if (power_cfg_i.off) begin
						state_q <= PWR_STEADY; // new off aborts the ramp
					end else if (pwm_wrap && step_cnt_q == STEP_LAST) begin
						state_q <= PWR_STEADY; // all steps done
					end
				end
				default: state_q <= PWR_STEADY;
			endcase
		end
	end

	// pwm during the ramp, otherwise the registered off bit
	assign targetpower_off_o = (state_q == PWR_RAMP) ? pwm_on : off_q;

endmodule

/* source/cw_route_top.sv */
`timescale 1ns/1ps

module cw_route_top #(
	parameter int unsigned PWM_WIDTH        = 11,    // soft start pwm counter bits
	parameter int unsigned PWM_ON_THRESHOLD = 1400,  // high cycles per pwm period
	parameter int unsigned SOFTSTART_STEPS  = 16384  // pwm periods per ramp
) (
	input  logic                                                      clk,
	input  logic                                                      reset,
	input  cw_route_pkg::apb_req_t                                    apb_i,
	output cw_route_pkg::apb_rsp_t                                    apb_o,
	input  cw_route_pkg::trig_lines_t                                 trig_lines_i,
	input  logic                                                      trigger_advio_i,
	input  logic                                                      trigger_anapattern_i,
	output logic                                                      trigger_ext_o,
	output logic                                                      trigger_o,
	input  logic [cw_route_pkg::N_TARGET_PINS-1:0]                    targetio_i,
	output cw_route_pkg::pin_drive_t [cw_route_pkg::N_TARGET_PINS-1:0] targetio_o,
	input  logic                                                      uart_tx_i,
	input  logic                                                      usi_out_i,
	output logic                                                      uart_rx_o,
	output logic                                                      usi_in_o,
	output logic                                                      targetpower_off_o
);
	import cw_route_pkg::*;

	trig_cfg_t                      trig_cfg;  // trigger mask, combine, module
	pin_route_t [N_TARGET_PINS-1:0] pin_route; // one routing byte per pin
	power_cfg_t                     power_cfg;

	cw_apb_regs u_regs (
		.clk         (clk),
		.reset       (reset),
		.apb_i       (apb_i),
		.apb_o       (apb_o),
		.trig_cfg_o  (trig_cfg),
		.pin_route_o (pin_route),
		.power_cfg_o (power_cfg)
	);

	trigger_combiner u_trig (
		.trig_cfg_i           (trig_cfg),
		.trig_lines_i         (trig_lines_i),
		.trigger_advio_i      (trigger_advio_i),
		.trigger_anapattern_i (trigger_anapattern_i),
		.trigger_ext_o        (trigger_ext_o),
		.trigger_o            (trigger_o)
	);

	target_io_router u_io (
		.pin_route_i (pin_route),
		.targetio_i  (targetio_i),
		.uart_tx_i   (uart_tx_i),
		.usi_out_i   (usi_out_i),
		.targetio_o  (targetio_o),
		.uart_rx_o   (uart_rx_o),
		.usi_in_o    (usi_in_o)
	);

	target_power_softstart #(
		.PWM_WIDTH        (PWM_WIDTH),
		.PWM_ON_THRESHOLD (PWM_ON_THRESHOLD),
		.SOFTSTART_STEPS  (SOFTSTART_STEPS)
	) u_power (
		.clk               (clk),
		.reset             (reset),
		.power_cfg_i       (power_cfg),
		.targetpower_off_o (targetpower_off_o)
	);

endmodule

/* verification/cw_route_sva.sv */
`timescale 1ns/1ps

module cw_route_sva (
	input logic                     clk,
	input logic                     reset,
	input cw_route_pkg::apb_req_t   apb_req_i,
	input cw_route_pkg::apb_rsp_t   apb_rsp_i,
	input logic                     off_cfg_i,   // off bit as held in the power register
	input cw_route_pkg::pwr_state_e pwr_state_i,
	input logic                     targetpower_off_i
);
	import cw_route_pkg::*;

	int fail_cnt = 0; // read by the testbench at the end

	// zero wait state slave
	pready_high: assert property (@(posedge clk) disable iff (reset) apb_rsp_i.pready)
		else begin
			$error("pready dropped low");
			fail_cnt++;
		end

	slverr_in_access: assert property (@(posedge clk) disable iff (reset)
		apb_rsp_i.pslverr |-> apb_req_i.psel && apb_req_i.penable)
		else begin
			$error("pslverr raised outside an access phase");
			fail_cnt++;
		end

	// power stays on unless off was set a cycle earlier or the pwm ramp runs
	power_stays_on: assert property (@(posedge clk) disable iff (reset)
		(!$past(off_cfg_i) && pwr_state_i != PWR_RAMP) |-> !targetpower_off_i)
		else begin
			$error("target power switched off with off bit clear and no ramp");
			fail_cnt++;
		end

endmodule

bind cw_route_top cw_route_sva u_sva (
	.clk               (clk),
	.reset             (reset),
	.apb_req_i         (apb_i),
	.apb_rsp_i         (apb_o),
	.off_cfg_i         (power_cfg.off),
	.pwr_state_i       (u_power.state_q),
	.targetpower_off_i (targetpower_off_o)
);

/* verification/cw_route_tb.sv */
`timescale 1ns/1ps

module cw_route_tb;
	import cw_route_pkg::*;

	localparam int PERIOD = 8;          // pwm period, 2**PWM_WIDTH
	localparam int RAMP   = 4 * PERIOD; // four soft start steps
	localparam int N_CFG  = 16;         // configs per random test, 8 vectors each
	localparam int N_VEC  = 2 * N_CFG * 8;
	localparam int N_APB  = 21 + 11 + 2 * N_CFG + 4 * N_CFG + 7;
	localparam int WATCHDOG_NS = (N_APB * 2 + N_VEC + 2 * RAMP + 100) * 8;

	logic             clk = 1'b0;
	logic             reset = 1'b1;
	apb_req_t         apb_req;
	apb_rsp_t         apb_rsp;
	trig_lines_t      trig_lines;
	logic             advio;
	logic             anapattern;
	logic             trig_ext;
	logic             trig_out;
	logic [3:0]       tio_in;
	pin_drive_t [3:0] tio_out;
	logic             uart_tx;
	logic             usi_out;
	logic             uart_rx;
	logic             usi_in;
	logic             power_off;
	logic [31:0]      seed = 32'hea2c_0c3d;
	int               n_checks = 0;
	int               n_errors = 0;
	int               n_tests = 0;
	logic [7:0]       reg_addr [7] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14, 8'h18};
	logic [7:0]       exp_reg [7] = '{8'h01, 8'h00, 8'h01, 8'h02, 8'h00, 8'h00, 8'h00};
	logic [7:0]       route [4]; // routing byte per pin as written
	logic [31:0]      rdata;     // last access phase response
	logic             err;

	always #4 clk = ~clk;

	cw_route_top #(.PWM_WIDTH(3), .PWM_ON_THRESHOLD(5), .SOFTSTART_STEPS(4)) DUT (
		.clk (clk), .reset (reset), .apb_i (apb_req), .apb_o (apb_rsp),
		.trig_lines_i (trig_lines), .trigger_advio_i (advio),
		.trigger_anapattern_i (anapattern), .trigger_ext_o (trig_ext), .trigger_o (trig_out),
		.targetio_i (tio_in), .targetio_o (tio_out), .uart_tx_i (uart_tx), .usi_out_i (usi_out),
		.uart_rx_o (uart_rx), .usi_in_o (usi_in), .targetpower_off_o (power_off)
	);

	function logic [31:0] lcg();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// enabled lines combined, empty mask gives 0 for OR and 1 for AND
	function automatic logic exp_ext(logic [7:0] src, logic [5:0] lines);
		logic any_on;
		logic all_on;
		any_on = 1'b0;
		all_on = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (src[i]) begin
				any_on |= lines[i];
				all_on &= lines[i];
			end
		end
		return (src[7:6] == 2'd0) ? any_on : (src[7:6] == 2'd1) ? all_on : 1'b0;
	endfunction

	// pin drive by priority, index 2 is pin 3
	function automatic pin_drive_t exp_pin(int p, logic [7:0] r, logic tx, logic usi);
		pin_drive_t d;
		d = '0;
		if (r[0])
			d = {1'b1, tx};
		else if (p < 3 && r[2])
			d = {1'b1, usi};
		else if (p == 2 && r[4])
			d = {~usi, 1'b0}; // open collector pulls low
		else if (p == 2 && r[5])
			d = {~tx, 1'b0};
		else if (r[7])
			d = {1'b1, r[6]};
		return d;
	endfunction

	// lowest pin with the receive bit set, idle 1
	function automatic logic exp_rx(int b, int npins, logic [3:0] ins);
		for (int p = 0; p < npins; p++) begin
			if (route[p][b])
				return ins[p];
		end
		return 1'b1;
	endfunction

	task automatic check(string name, logic [31:0] exp, logic [31:0] got);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("ERROR %s expected 0x%h actual 0x%h", name, exp, got);
		end
	endtask

	// setup then access phase, response taken at the closing edge
	task automatic apb(logic wr, logic [7:0] addr, logic [31:0] wdata);
		@(negedge clk);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apb_req.penable = 1'b1;
		@(posedge clk);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
	endtask

	task automatic wr_reg(logic [7:0] addr, logic [31:0] data);
		apb(1'b1, addr, data);
		check($sformatf("pslverr@%h", addr), 0, err);
	endtask

	task automatic rd_check(logic [7:0] addr, logic [7:0] exp);
		apb(1'b0, addr, 32'h0);
		check($sformatf("prdata@%h", addr), {24'h0, exp}, rdata); // upper bits zero
		check($sformatf("pslverr@%h", addr), 0, err);
	endtask

	task automatic bus_idle();
		@(negedge clk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic finish_test(string name);
		n_tests++;
		$display("test %0d %s done, errors so far %0d", n_tests, name, n_errors);
	endtask

	initial begin
		logic [7:0] src;
		logic [7:0] mode;
		logic [31:0] r;
		logic ext;
		logic trg;
		logic pexp;
		pin_drive_t d;
		apb_req    = '0;
		trig_lines = '0;
		advio      = 1'b0;
		anapattern = 1'b0;
		tio_in     = '0;
		uart_tx    = 1'b0;
		usi_out    = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// reset state, only pin 1 drives (uart tx)
		check("targetpower_off_o", 0, power_off);
		for (int p = 0; p < 4; p++)
			check($sformatf("targetio_o[%0d].oe", p), p == 0, tio_out[p].oe);
		for (int i = 0; i < 7; i++)
			rd_check(reg_addr[i], exp_reg[i]);
		for (int i = 0; i < 7; i++) begin
			r = lcg();
			wr_reg(reg_addr[i], r); // full word, only low byte kept
			exp_reg[i] = r[7:0];
		end
		for (int i = 0; i < 7; i++)
			rd_check(reg_addr[i], exp_reg[i]);
		bus_idle();
		finish_test("reset values and readback");

		for (int i = 0; i < 2; i++) begin
			apb(1'b1, i ? 8'h40 : 8'h1C, lcg());
			check("pslverr", 1, err);
			apb(1'b0, i ? 8'h40 : 8'h1C, 32'h0);
			check("pslverr", 1, err);
			check("prdata", 0, rdata);
		end
		for (int i = 0; i < 7; i++)
			rd_check(reg_addr[i], exp_reg[i]); // nothing changed
		bus_idle();
		finish_test("unmapped addresses");

		for (int c = 0; c < N_CFG; c++) begin
			r    = lcg();
			src  = (c == 0) ? 8'h00 : (c == 1) ? 8'h40 : r[7:0]; // empty mask, OR then AND
			mode = (c < 8) ? 8'(c) : r[15:8];                     // every module code once
			wr_reg(8'h00, src);
			wr_reg(8'h04, mode);
			bus_idle();
			for (int v = 0; v < 8; v++) begin
				@(negedge clk);
				r          = lcg();
				trig_lines = r[5:0];
				advio      = r[6];
				anapattern = r[7];
				@(posedge clk);
				ext = exp_ext(src, r[5:0]);
				case (mode[2:0])
					3'd0:    trg = ext;
					3'd1:    trg = r[6];
					3'd2:    trg = r[7];
					default: trg = 1'b0;
				endcase
				check("trigger_ext_o", ext, trig_ext);
				check("trigger_o", trg, trig_out);
			end
		end
		finish_test("trigger combining and selection");

		for (int c = 0; c < N_CFG; c++) begin
			r = lcg();
			for (int p = 0; p < 4; p++)
				route[p] = (c < 3) ? 8'h00 : r[8*p +: 8]; // first one: no receiver routed
			if (c == 1)
				route[2] = 8'h10; // pin 3 usi open collector
			if (c == 2)
				route[2] = 8'h20; // pin 3 uart tx open collector
			for (int p = 0; p < 4; p++)
				wr_reg(8'h08 + 8'(4 * p), route[p]);
			bus_idle();
			for (int v = 0; v < 8; v++) begin
				@(negedge clk);
				r       = lcg();
				uart_tx = r[0];
				usi_out = r[1];
				tio_in  = r[5:2];
				@(posedge clk);
				for (int p = 0; p < 4; p++) begin
					d = exp_pin(p, route[p], r[0], r[1]);
					check($sformatf("targetio_o[%0d].oe", p), d.oe, tio_out[p].oe);
					if (d.oe)
						check($sformatf("targetio_o[%0d].value", p), d.value, tio_out[p].value);
				end
				check("uart_rx_o", exp_rx(1, 4, r[5:2]), uart_rx);
				check("usi_in_o", exp_rx(3, 3, r[5:2]), usi_in);
			end
		end
		finish_test("pin routing");

		wr_reg(8'h18, 8'h01); // off, slow start
		bus_idle();
		repeat (2) @(negedge clk);
		check("targetpower_off_o", 1, power_off);
		wr_reg(8'h18, 8'h00);
		bus_idle();
		for (int i = 0; i <= RAMP + 4; i++) begin
			// one edge of latency, then 4 pwm periods high for 5 cycles, then on
			pexp = (i == 0) || (i <= RAMP && (i - 1) % PERIOD < 5);
			check("targetpower_off_o", pexp, power_off);
			@(negedge clk);
		end
		wr_reg(8'h18, 8'h03);
		bus_idle();
		repeat (2) @(negedge clk);
		wr_reg(8'h18, 8'h02); // fast start, no ramp
		bus_idle();
		for (int i = 0; i < 10; i++) begin
			check("targetpower_off_o", i == 0, power_off);
			@(negedge clk);
		end
		wr_reg(8'h18, 8'h01);
		bus_idle();
		repeat (2) @(negedge clk);
		wr_reg(8'h18, 8'h00);
		bus_idle();
		repeat (3) @(negedge clk);
		wr_reg(8'h18, 8'h01); // off again in the middle of the ramp
		bus_idle();
		for (int i = 1; i <= 12; i++) begin
			@(negedge clk);
			check("targetpower_off_o", 1, power_off); // no low pwm phase left
		end
		finish_test("power and soft start");

		n_errors += DUT.u_sva.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout, tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sources.f */
source/cw_route_pkg.sv
source/cw_apb_regs.sv
source/trigger_combiner.sv
source/target_io_router.sv
source/target_power_softstart.sv
source/cw_route_top.sv
verification/cw_route_sva.sv
verification/cw_route_tb.sv

/* Bender.yml */
package:
  name: cw_route

sources:
  - source/cw_route_pkg.sv
  - source/cw_apb_regs.sv
  - source/trigger_combiner.sv
  - source/target_io_router.sv
  - source/target_power_softstart.sv
  - source/cw_route_top.sv
  - target: test
    files:
      - verification/cw_route_sva.sv
      - verification/cw_route_tb.sv
